// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := tb_iodly_ctrl
FILELIST   := all.f
OBJ_DIR    := obj_dir
PASS_MSG   := RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
source/iodly_pkg.sv
source/iodly_axi4l_slave.sv
source/iodly_regs.sv
source/iodly_ctrl.sv
dv/iodly_ctrl_checker.sv
dv/tb_iodly_ctrl.sv

// ==== dv/iodly_ctrl_checker.sv ====
`timescale 1ns/1ps

module iodly_ctrl_checker
    import iodly_pkg::*;
(
    input logic      sys__clk,
    input logic      sys__srstn,
    input logic      ctrl_awready,
    input logic      ctrl_bvalid,
    input logic      ctrl_bready,
    input logic      ctrl_rvalid,
    input logic      ctrl_rready,
    input reg_data_t ctrl_rdata,
    input tap_load_t tap_load
);

    a_bvalid_hold: assert property (@(posedge sys__clk) disable iff (!sys__srstn)
        ctrl_bvalid && !ctrl_bready |=> ctrl_bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge sys__clk) disable iff (!sys__srstn)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid)
        else $error("rvalid dropped before rready");

    // Read data is frozen under back-pressure.
    a_rdata_stable: assert property (@(posedge sys__clk) disable iff (!sys__srstn)
        ctrl_rvalid && !ctrl_rready |=> $stable(ctrl_rdata))
        else $error("rdata changed while waiting for rready");

    a_pulse_single: assert property (@(posedge sys__clk) disable iff (!sys__srstn)
        tap_load.pulse |=> !tap_load.pulse)
        else $error("load pulse longer than one cycle");

    a_aw_blocked: assert property (@(posedge sys__clk) disable iff (!sys__srstn)
        !(ctrl_awready && ctrl_bvalid))
        else $error("awready high during a pending write response");

endmodule

bind iodly_ctrl iodly_ctrl_checker u_checker (
    .sys__clk     (sys__clk),
    .sys__srstn   (sys__srstn),
    .ctrl_awready (ctrl_awready),
    .ctrl_bvalid  (ctrl_bvalid),
    .ctrl_bready  (ctrl_bready),
    .ctrl_rvalid  (ctrl_rvalid),
    .ctrl_rready  (ctrl_rready),
    .ctrl_rdata   (ctrl_rdata),
    .tap_load     (tap_load)
);

// ==== dv/tb_iodly_ctrl.sv ====
`timescale 1ns/1ps

module tb_iodly_ctrl
    import iodly_pkg::*;
();

    localparam logic [31:0] SEED = 32'hb6fcabb6;
    // About 150 transactions of up to 20 cycles, doubled.
    localparam int MAX_CYCLES = 150 * 20 * 2;

    logic       sys__clk;
    logic       sys__srstn;
    axi_addr_t  ctrl_awaddr;
    logic [2:0] ctrl_awprot;
    logic       ctrl_awvalid;
    logic       ctrl_awready;
    reg_data_t  ctrl_wdata;
    logic [3:0] ctrl_wstrb;
    logic       ctrl_wvalid;
    logic       ctrl_wready;
    axi_resp_t  ctrl_bresp;
    logic       ctrl_bvalid;
    logic       ctrl_bready;
    axi_addr_t  ctrl_araddr;
    logic [2:0] ctrl_arprot;
    logic       ctrl_arvalid;
    logic       ctrl_arready;
    reg_data_t  ctrl_rdata;
    axi_resp_t  ctrl_rresp;
    logic       ctrl_rvalid;
    logic       ctrl_rready;
    tap_array_t taps;
    tap_load_t  tap_load;

    // Expected outputs, kept from the register map rules.
    tap_t       exp_taps [NUM_TAPS];
    tap_load_t  exp_load;
    // Outputs seen at the first bvalid cycle and one cycle later.
    tap_load_t  load_at_b;
    tap_load_t  load_after;
    tap_array_t taps_after;
    int         n_pass;
    int         n_fail;
    int         cycles;

    iodly_ctrl dut (.*);

    always #4 sys__clk = ~sys__clk;

    task automatic tally_check(input bit ok, input string name, input string expected,
                               input string actual);
        if (ok)
            n_pass++;
        else
        begin
            $display("Fail at %0t ns: %s expected %s, got %s", $time, name, expected, actual);
            n_fail++;
        end
    endtask

    task automatic check_data(input string name, input reg_data_t expected,
                              input reg_data_t actual);
        tally_check(actual === expected, name, $sformatf("%h", expected),
                    $sformatf("%h", actual));
    endtask

    task automatic check_tap(input string name, input tap_t expected, input tap_t actual);
        tally_check(actual === expected, name, $sformatf("%h", expected),
                    $sformatf("%h", actual));
    endtask

    task automatic check_load(input string name, input tap_load_t expected,
                              input tap_load_t actual);
        tally_check(actual === expected, name, $sformatf("%b", expected),
                    $sformatf("%b", actual));
    endtask

    task automatic check_resp(input string name, input axi_resp_t expected,
                              input axi_resp_t actual);
        tally_check(actual === expected, name, $sformatf("%b", expected),
                    $sformatf("%b", actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        tally_check(actual === expected, name, $sformatf("%b", expected),
                    $sformatf("%b", actual));
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        n_fail++;
    endtask

    task automatic check_taps(input tap_array_t actual);
        for (int i = 0; i < NUM_TAPS; i++)
            check_tap($sformatf("taps[%0d]", i), exp_taps[i], actual[i]);
    endtask

    function automatic axi_addr_t tap_addr(input int idx);
        return 32'h0000_8000 | axi_addr_t'(idx << 2);
    endfunction

    function automatic axi_addr_t ctrl_addr(input int idx);
        return axi_addr_t'(idx << 2);
    endfunction

    function automatic reg_data_t widen_tap(input tap_t t);
        return {{(DATA_WIDTH-TAP_WIDTH){1'b0}}, t};
    endfunction

    task automatic next_cycle();
        @(posedge sys__clk);
        #1;
    endtask

    // Bready stays low for the first response cycle, plus the stall.
    task automatic axi_write(input axi_addr_t addr, input reg_data_t data, input int stall = 0);
        ctrl_awaddr  = addr;
        ctrl_wdata   = data;
        ctrl_awvalid = 1'b1;
        ctrl_wvalid  = 1'b1;
        #1;
        check_flag("ctrl_awready", 1'b1, ctrl_awready);
        check_flag("ctrl_wready", 1'b1, ctrl_wready);
        next_cycle();
        while (!ctrl_bvalid)
            next_cycle();
        ctrl_awvalid = 1'b0;
        ctrl_wvalid  = 1'b0;
        load_at_b    = tap_load;
        check_resp("ctrl_bresp", RESP_OKAY, ctrl_bresp);
        next_cycle();
        taps_after = taps;
        load_after = tap_load;
        repeat (stall)
        begin
            if (!ctrl_bvalid)
                report_error("bvalid dropped before bready");
            next_cycle();
        end
        if (!ctrl_bvalid)
            report_error("bvalid dropped before bready");
        ctrl_bready = 1'b1;
        next_cycle();
        ctrl_bready = 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, input reg_data_t expected,
                            input int stall = 0);
        int lat;
        ctrl_araddr  = addr;
        ctrl_arvalid = 1'b1;
        while (!ctrl_arready)
            next_cycle();
        next_cycle();
        ctrl_arvalid = 1'b0;
        lat = 0;
        while (!ctrl_rvalid)
        begin
            next_cycle();
            lat++;
        end
        if (lat != 2)
            report_error($sformatf("read data came %0d cycles after the AR handshake", lat));
        check_data("ctrl_rdata", expected, ctrl_rdata);
        check_resp("ctrl_rresp", RESP_OKAY, ctrl_rresp);
        repeat (stall)
        begin
            next_cycle();
            if (!ctrl_rvalid)
                report_error("rvalid dropped before rready");
            check_data("ctrl_rdata", expected, ctrl_rdata);
        end
        ctrl_rready = 1'b1;
        next_cycle();
        ctrl_rready = 1'b0;
    endtask

    task automatic end_test(input string name, input int fails_before);
        if (n_fail == fails_before)
            $display("Test %s: passed", name);
        else
            $display("Test %s: failed, %0d errors", name, n_fail - fails_before);
    endtask

    task automatic reset_state();
        int f0;
        f0 = n_fail;
        if (!ctrl_arready || ctrl_awready || ctrl_wready || ctrl_bvalid || ctrl_rvalid)
            report_error("handshake outputs not in their reset state");
        check_taps(taps);
        check_load("tap_load", exp_load, tap_load);
        axi_read(ctrl_addr(int'(CTRL_IDX_ID)), ID_WORD);
        axi_write(ctrl_addr(3), $urandom);
        check_taps(taps);
        check_load("tap_load", exp_load, tap_load);
        end_test("reset state", f0);
    endtask

    task automatic tap_write_readback();
        reg_data_t data;
        int f0;
        f0 = n_fail;
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            data = $urandom;
            axi_write(tap_addr(i), data);
            exp_taps[i] = data[TAP_WIDTH-1:0];
            check_taps(taps_after);
        end
        for (int i = 0; i < NUM_TAPS; i++)
            axi_read(tap_addr(i), widen_tap(exp_taps[i]));
        end_test("tap write and readback", f0);
    endtask

    task automatic load_pulse();
        tap_load_t pulse_on;
        int f0;
        f0 = n_fail;
        pulse_on       = exp_load;
        pulse_on.pulse = 1'b1;
        axi_write(ctrl_addr(int'(CTRL_IDX_LOAD)), $urandom);
        check_load("tap_load at bvalid", exp_load, load_at_b);
        check_load("tap_load after bvalid", pulse_on, load_after);
        check_load("tap_load", exp_load, tap_load);
        axi_read(ctrl_addr(int'(CTRL_IDX_LOAD)), '0);
        end_test("load pulse", f0);
    endtask

    task automatic load_mode();
        reg_data_t data;
        int f0;
        f0 = n_fail;
        axi_write(ctrl_addr(int'(CTRL_IDX_MODE)), $urandom | 32'd1);
        exp_load.mode = 1'b1;
        check_load("tap_load", exp_load, tap_load);
        data = $urandom;
        axi_write(tap_addr(7), data);
        exp_taps[7] = data[TAP_WIDTH-1:0];
        axi_write(ctrl_addr(int'(CTRL_IDX_ID)), $urandom);
        check_taps(taps);
        check_load("tap_load", exp_load, tap_load);
        axi_read(ctrl_addr(int'(CTRL_IDX_MODE)), '0);
        axi_write(ctrl_addr(int'(CTRL_IDX_MODE)), $urandom & ~32'd1);
        exp_load.mode = 1'b0;
        check_load("tap_load", exp_load, tap_load);
        end_test("load mode", f0);
    endtask

    task automatic unmapped_and_stall();
        reg_data_t data;
        int idx;
        int f0;
        f0 = n_fail;
        axi_write(tap_addr(40), $urandom);
        axi_write(ctrl_addr(5), $urandom);
        check_taps(taps);
        check_load("tap_load", exp_load, tap_load);
        axi_read(tap_addr(40), '0);
        axi_read(ctrl_addr(5), '0);
        for (int k = 0; k < 8; k++)
        begin
            idx  = int'($urandom % NUM_TAPS);
            data = $urandom;
            axi_write(tap_addr(idx), data, int'($urandom % 8));
            exp_taps[idx] = data[TAP_WIDTH-1:0];
            check_taps(taps);
            axi_read(tap_addr(idx), widen_tap(exp_taps[idx]), 1 + int'($urandom % 8));
        end
        axi_read(ctrl_addr(int'(CTRL_IDX_ID)), ID_WORD);
        end_test("unmapped addresses and back-pressure", f0);
    endtask

    initial
    begin
        sys__clk     = 1'b0;
        sys__srstn   = 1'b0;
        ctrl_awaddr  = '0;
        ctrl_awprot  = '0;
        ctrl_awvalid = 1'b0;
        ctrl_wdata   = '0;
        ctrl_wstrb   = 4'hf;
        ctrl_wvalid  = 1'b0;
        ctrl_bready  = 1'b0;
        ctrl_araddr  = '0;
        ctrl_arprot  = '0;
        ctrl_arvalid = 1'b0;
        ctrl_rready  = 1'b0;
        n_pass       = 0;
        n_fail       = 0;
        exp_load     = '0;
        for (int i = 0; i < NUM_TAPS; i++)
            exp_taps[i] = '0;
        void'($urandom(SEED));
        repeat (16)
            @(posedge sys__clk);
        #1;
        sys__srstn = 1'b1;
        next_cycle();
        reset_state();
        tap_write_readback();
        load_pulse();
        load_mode();
        unmapped_and_stall();
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge sys__clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== source/iodly_axi4l_slave.sv ====
`timescale 1ns/1ps

module iodly_axi4l_slave
    import iodly_pkg::*;
(
    input  logic        sys__clk,
    input  logic        sys__srstn,

    input  axi_addr_t   ctrl_awaddr,
    input  logic [2:0]  ctrl_awprot,
    input  logic        ctrl_awvalid,
    output logic        ctrl_awready,
    input  reg_data_t   ctrl_wdata,
    input  logic [3:0]  ctrl_wstrb,
    input  logic        ctrl_wvalid,
    output logic        ctrl_wready,
    output axi_resp_t   ctrl_bresp,
    output logic        ctrl_bvalid,
    input  logic        ctrl_bready,

    input  axi_addr_t   ctrl_araddr,
    input  logic [2:0]  ctrl_arprot,
    input  logic        ctrl_arvalid,
    output logic        ctrl_arready,
    output reg_data_t   ctrl_rdata,
    output axi_resp_t   ctrl_rresp,
    output logic        ctrl_rvalid,
    input  logic        ctrl_rready,

    output reg_wr_t     wr_req,
    output reg_rd_req_t rd_req,
    input  reg_rd_rsp_t rd_rsp
);

    wr_state_t wr_state;
    rd_state_t rd_state;

    logic      wr_hs;
    logic      rd_hs;

    logic      wr_valid_q;
    reg_addr_t wr_addr_q;
    reg_data_t wr_data_q;

    logic      rd_valid_q;
    reg_addr_t rd_addr_q;
    reg_data_t rdata_q;

    // Word index sits above the byte offset.
    function automatic reg_addr_t to_reg_addr(input axi_addr_t addr);
        reg_addr_t ra;
        ra.space = addr[IDX_WIDTH+2];
        ra.idx   = addr[IDX_WIDTH+1:2];
        return ra;
    endfunction

    // AW and W are taken together.
    assign wr_hs        = (wr_state == WR_IDLE) && ctrl_awvalid && ctrl_wvalid;
    assign ctrl_awready = wr_hs;
    assign ctrl_wready  = wr_hs;
    assign ctrl_bvalid  = (wr_state == WR_RESP);
    assign ctrl_bresp   = RESP_OKAY;

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            wr_state <= WR_IDLE;
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (wr_hs)
                        wr_state <= WR_RESP;
                end
                WR_RESP:
                begin
                    if (ctrl_bready)
                        wr_state <= WR_IDLE;
                end
                default:
                    wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            wr_valid_q <= 1'b0;
        else
            wr_valid_q <= wr_hs;
    end

    always_ff @(posedge sys__clk)
    begin
        if (wr_hs)
        begin
            wr_addr_q <= to_reg_addr(ctrl_awaddr);
            wr_data_q <= ctrl_wdata;
        end
    end

    assign wr_req = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q};

    // Read side.
    assign rd_hs        = (rd_state == RD_IDLE) && ctrl_arvalid;
    assign ctrl_arready = (rd_state == RD_IDLE);
    assign ctrl_rvalid  = (rd_state == RD_RESP);
    assign ctrl_rresp   = RESP_OKAY;
    assign ctrl_rdata   = rdata_q;

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            rd_state <= RD_IDLE;
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_hs)
                        rd_state <= RD_WAIT;
                end
                RD_WAIT:
                begin
                    if (rd_rsp.valid)
                        rd_state <= RD_RESP;
                end
                RD_RESP:
                begin
                    if (ctrl_rready)
                        rd_state <= RD_IDLE;
                end
                default:
                    rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            rd_valid_q <= 1'b0;
        else
            rd_valid_q <= rd_hs;
    end

    always_ff @(posedge sys__clk)
    begin
        if (rd_hs)
            rd_addr_q <= to_reg_addr(ctrl_araddr);
    end

    // Held until rready.
    always_ff @(posedge sys__clk)
    begin
        if ((rd_state == RD_WAIT) && rd_rsp.valid)
            rdata_q <= rd_rsp.data;
    end

    assign rd_req = '{valid: rd_valid_q, addr: rd_addr_q};

endmodule

// ==== source/iodly_ctrl.sv ====
`timescale 1ns/1ps

module iodly_ctrl
    import iodly_pkg::*;
(
    input  logic        sys__clk,
    input  logic        sys__srstn,

    input  axi_addr_t   ctrl_awaddr,
    input  logic [2:0]  ctrl_awprot,
    input  logic        ctrl_awvalid,
    output logic        ctrl_awready,
    input  reg_data_t   ctrl_wdata,
    input  logic [3:0]  ctrl_wstrb,
    input  logic        ctrl_wvalid,
    output logic        ctrl_wready,
    output axi_resp_t   ctrl_bresp,
    output logic        ctrl_bvalid,
    input  logic        ctrl_bready,

    input  axi_addr_t   ctrl_araddr,
    input  logic [2:0]  ctrl_arprot,
    input  logic        ctrl_arvalid,
    output logic        ctrl_arready,
    output reg_data_t   ctrl_rdata,
    output axi_resp_t   ctrl_rresp,
    output logic        ctrl_rvalid,
    input  logic        ctrl_rready,

    output tap_array_t  taps,
    output tap_load_t   tap_load
);

    reg_wr_t     wr_req;
    reg_rd_req_t rd_req;
    reg_rd_rsp_t rd_rsp;

    iodly_axi4l_slave u_slave (
        .sys__clk     (sys__clk),
        .sys__srstn   (sys__srstn),
        .ctrl_awaddr  (ctrl_awaddr),
        .ctrl_awprot  (ctrl_awprot),
        .ctrl_awvalid (ctrl_awvalid),
        .ctrl_awready (ctrl_awready),
        .ctrl_wdata   (ctrl_wdata),
        .ctrl_wstrb   (ctrl_wstrb),
        .ctrl_wvalid  (ctrl_wvalid),
        .ctrl_wready  (ctrl_wready),
        .ctrl_bresp   (ctrl_bresp),
        .ctrl_bvalid  (ctrl_bvalid),
        .ctrl_bready  (ctrl_bready),
        .ctrl_araddr  (ctrl_araddr),
        .ctrl_arprot  (ctrl_arprot),
        .ctrl_arvalid (ctrl_arvalid),
        .ctrl_arready (ctrl_arready),
        .ctrl_rdata   (ctrl_rdata),
        .ctrl_rresp   (ctrl_rresp),
        .ctrl_rvalid  (ctrl_rvalid),
        .ctrl_rready  (ctrl_rready),
        .wr_req       (wr_req),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp)
    );

    iodly_regs u_regs (
        .sys__clk   (sys__clk),
        .sys__srstn (sys__srstn),
        .wr_req     (wr_req),
        .rd_req     (rd_req),
        .rd_rsp     (rd_rsp),
        .taps       (taps),
        .tap_load   (tap_load)
    );

endmodule

// ==== source/iodly_pkg.sv ====
package iodly_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int TAP_WIDTH  = 9;
    localparam int NUM_TAPS   = 32;
    localparam int IDX_WIDTH  = 13;

    typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [DATA_WIDTH-1:0] reg_data_t;
    typedef logic [TAP_WIDTH-1:0]  tap_t;
    typedef logic [IDX_WIDTH-1:0]  reg_idx_t;
    typedef logic [1:0]            axi_resp_t;

    localparam reg_data_t ID_WORD       = 32'h69646c79;
    localparam reg_idx_t  CTRL_IDX_ID   = 13'd0;
    localparam reg_idx_t  CTRL_IDX_LOAD = 13'd1;
    localparam reg_idx_t  CTRL_IDX_MODE = 13'd2;
    localparam axi_resp_t RESP_OKAY     = 2'b00;

    // Space set selects the tap registers.
    typedef struct packed {
        logic     space;
        reg_idx_t idx;
    } reg_addr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
    } reg_rd_req_t;

    typedef struct packed {
        logic      valid;
        reg_data_t data;
    } reg_rd_rsp_t;

    typedef struct packed {
        logic pulse;
        logic mode;
    } tap_load_t;

    typedef tap_t [NUM_TAPS-1:0] tap_array_t;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

endpackage

// ==== source/iodly_regs.sv ====
`timescale 1ns/1ps

module iodly_regs
    import iodly_pkg::*;
(
    input  logic        sys__clk,
    input  logic        sys__srstn,

    input  reg_wr_t     wr_req,
    input  reg_rd_req_t rd_req,
    output reg_rd_rsp_t rd_rsp,

    output tap_array_t  taps,
    output tap_load_t   tap_load
);

    tap_array_t taps_q;
    logic       load_pulse_q;
    logic       load_mode_q;

    logic       wr_tap;
    logic       wr_ctrl;

    logic       rsp_valid_q;
    reg_data_t  rsp_data_q;
    reg_data_t  rd_data_next;

    assign wr_tap  = wr_req.valid && wr_req.addr.space &&
                     (wr_req.addr.idx < reg_idx_t'(NUM_TAPS));
    assign wr_ctrl = wr_req.valid && !wr_req.addr.space;

    // Only the low tap bits are stored.
    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            taps_q <= '0;
        else if (wr_tap)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                if (wr_req.addr.idx == reg_idx_t'(i))
                    taps_q[i] <= wr_req.data[TAP_WIDTH-1:0];
            end
        end
    end

    // One cycle per write.
    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            load_pulse_q <= 1'b0;
        else
            load_pulse_q <= wr_ctrl && (wr_req.addr.idx == CTRL_IDX_LOAD);
    end

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            load_mode_q <= 1'b0;
        else if (wr_ctrl && (wr_req.addr.idx == CTRL_IDX_MODE))
            load_mode_q <= wr_req.data[0];
    end

    // Readback mux.
    always_comb
    begin
        rd_data_next = '0;
        if (rd_req.addr.space)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                if (rd_req.addr.idx == reg_idx_t'(i))
                    rd_data_next = reg_data_t'(taps_q[i]);
            end
        end
        else if (rd_req.addr.idx == CTRL_IDX_ID)
        begin
            rd_data_next = ID_WORD;
        end
    end

    always_ff @(posedge sys__clk)
    begin
        if (!sys__srstn)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= rd_req.valid;
    end

    always_ff @(posedge sys__clk)
    begin
        if (rd_req.valid)
            rsp_data_q <= rd_data_next;
    end

    assign rd_rsp   = '{valid: rsp_valid_q, data: rsp_data_q};
    assign taps     = taps_q;
    assign tap_load = '{pulse: load_pulse_q, mode: load_mode_q};

endmodule
